/* list.f */
src/rp_pkg.sv
src/sys_bus_decoder.sv
src/rp_housekeeping.sv
src/rp_ams_regs.sv
src/rp_pdm.sv
src/rp_analog_io.sv
src/rp_top.sv
test/rp_top_assertions.sv
test/rp_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rp_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module rp_top_tb -o rp_top_sim
./obj_dir/rp_top_sim 2>&1 | tee sim.log

if grep -q "^Test completed successfully$" sim.log; then
  echo "simulation PASSED"
else
  echo "simulation FAILED, see sim.log"
  exit 1
fi

/* src/rp_ams_regs.sv */
//////////////////////////////////////////////////////////////////////
// analog mixed signal register block, region 4
// four PDM duty bytes, readable, driving the modulators
//////////////////////////////////////////////////////////////////////

module rp_ams_regs (
  input  logic                               adc_clk,
  input  logic                               reset_i,
  input  logic [rp_pkg::REG_W-1:0]           addr_i,
  input  rp_pkg::sys_data_t                  wdata_i,
  input  logic                               wen_i,
  input  logic                               ren_i,
  output rp_pkg::sys_data_t                  rdata_o,
  output logic                               ack_o,
  output logic [rp_pkg::N_PDM-1:0][7:0]      pdm_cfg_o  // duty per channel
);
  import rp_pkg::*;

  // config bytes, new value visible the cycle after the write
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      pdm_cfg_o <= '0;  // outputs idle low
    else if (wen_i)
    begin
      case (addr_i)
        AMS_PDM0: pdm_cfg_o[0] <= wdata_i[7:0];
        AMS_PDM1: pdm_cfg_o[1] <= wdata_i[7:0];
        AMS_PDM2: pdm_cfg_o[2] <= wdata_i[7:0];
        AMS_PDM3: pdm_cfg_o[3] <= wdata_i[7:0];
        default:  ;
      endcase
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
    begin
      case (addr_i)
        AMS_PDM0: rdata_o <= {24'd0, pdm_cfg_o[0]};
        AMS_PDM1: rdata_o <= {24'd0, pdm_cfg_o[1]};
        AMS_PDM2: rdata_o <= {24'd0, pdm_cfg_o[2]};
        AMS_PDM3: rdata_o <= {24'd0, pdm_cfg_o[3]};
        default:  rdata_o <= '0;  // unmapped offset
      endcase
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      ack_o <= 1'b0;
    else
      ack_o <= wen_i | ren_i;  // one cycle after strobe
  end

endmodule

/* src/rp_analog_io.sv */
//////////////////////////////////////////////////////////////////////
// analog data path, two channels
// ADC input registers and negative slope to two's complement
// ASG plus PID sum with saturation to 14 bits
// DAC output registers, back to negative slope offset binary
// digital loop feeds the saturated sum into the acquire side
//////////////////////////////////////////////////////////////////////

module rp_analog_io (
  input  logic                              adc_clk,
  input  logic                              reset_i,
  input  logic [1:0][rp_pkg::ADC_W-1:0]     adc_dat_i,  // raw ADC words
  input  rp_pkg::smp_t [1:0]                gen_asg_i,  // generator stream
  input  rp_pkg::smp_t [1:0]                gen_pid_i,  // controller stream
  input  logic                              digital_loop_i,
  output rp_pkg::smp_t [1:0]                acq_o,      // acquired samples
  output logic [1:0][rp_pkg::SMP_W-1:0]     dac_o       // DAC codes
);
  import rp_pkg::*;

  logic [1:0][SMP_W-1:0] adc_raw_q;      // upper 14 bits of ADC word
  smp_t [1:0]            adc_conv;       // two's complement ADC
  logic signed [SMP_W:0] gen_sum [2];    // one guard bit
  smp_t [1:0]            gen_sat;        // clipped generator sum

  // MSB kept, rest inverted, works in both directions
  function automatic logic [SMP_W-1:0] flip_slope(input logic [SMP_W-1:0] code);
    return {code[SMP_W-1], ~code[SMP_W-2:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // acquire side input registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    for (int ch = 0; ch < 2; ch++)
      adc_raw_q[ch] <= adc_dat_i[ch][ADC_W-1:ADC_W-SMP_W];  // drop reserved bits
  end

  //////////////////////////////////////////////////////////////////////
  // conversion, summing and saturation
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < 2; ch++)
    begin
      adc_conv[ch] = flip_slope(adc_raw_q[ch]);
      gen_sum[ch]  = {gen_asg_i[ch][SMP_W-1], gen_asg_i[ch]}
                   + {gen_pid_i[ch][SMP_W-1], gen_pid_i[ch]};
      // top two bits disagree on overflow, clip toward the sign
      if (gen_sum[ch][SMP_W] != gen_sum[ch][SMP_W-1])
        gen_sat[ch] = {gen_sum[ch][SMP_W], {(SMP_W-1){~gen_sum[ch][SMP_W]}}};
      else
        gen_sat[ch] = gen_sum[ch][SMP_W-1:0];
    end
  end

  // output registers for both directions
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      acq_o <= '0;
      dac_o <= '0;
    end
    else
    begin
      for (int ch = 0; ch < 2; ch++)
      begin
        dac_o[ch] <= flip_slope(gen_sat[ch]);  // back to DAC code
        acq_o[ch] <= digital_loop_i ? gen_sat[ch] : adc_conv[ch];
      end
    end
  end

endmodule

/* src/rp_housekeeping.sv */
//////////////////////////////////////////////////////////////////////
// housekeeping register block, region 0
// identification word, digital loop switch, LED register
// one cycle ack for every strobe, unknown offsets read zero
//////////////////////////////////////////////////////////////////////

module rp_housekeeping (
  input  logic                     adc_clk,
  input  logic                     reset_i,
  input  logic [rp_pkg::REG_W-1:0] addr_i,
  input  rp_pkg::sys_data_t        wdata_i,
  input  logic                     wen_i,
  input  logic                     ren_i,
  output rp_pkg::sys_data_t        rdata_o,
  output logic                     ack_o,
  output logic                     digital_loop_o,  // ADC path takes DAC samples
  output logic [7:0]               led_o
);
  import rp_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // writable registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      digital_loop_o <= 1'b0;  // normal acquisition
      led_o          <= '0;    // all LEDs dark
    end
    else if (wen_i)
    begin
      case (addr_i)
        HK_DIGLOOP: digital_loop_o <= wdata_i[0];
        HK_LED:     led_o          <= wdata_i[7:0];
        default:    ;  // ID and holes ignore writes
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read back and ack
  //////////////////////////////////////////////////////////////////////

  // read data, valid in the ack cycle
  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
    begin
      case (addr_i)
        HK_ID:      rdata_o <= RP_ID;
        HK_DIGLOOP: rdata_o <= {31'd0, digital_loop_o};
        HK_LED:     rdata_o <= {24'd0, led_o};
        default:    rdata_o <= '0;
      endcase
    end
  end

  // write or read, both acked next cycle
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      ack_o <= 1'b0;
    else
      ack_o <= wen_i | ren_i;
  end

endmodule

/* src/rp_pdm.sv */
//////////////////////////////////////////////////////////////////////
// four channel first order PDM modulator
// 8 bit phase accumulator per channel, carry is the output bit
// full 255 range, always enabled
//////////////////////////////////////////////////////////////////////

module rp_pdm (
  input  logic                          adc_clk,
  input  logic                          reset_i,
  input  logic [rp_pkg::N_PDM-1:0][7:0] cfg_i,  // ones per 256 cycles
  output logic [rp_pkg::N_PDM-1:0]      pdm_o
);
  import rp_pkg::*;

  logic [N_PDM-1:0][7:0] acc_q;            // accumulator state
  logic [8:0]            acc_nxt [N_PDM];  // sum with carry

  always_comb
  begin
    for (int i = 0; i < N_PDM; i++)
      acc_nxt[i] = {1'b0, acc_q[i]} + {1'b0, cfg_i[i]};
  end

  // accumulator wraps every 256 steps with exactly cfg carries
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      acc_q <= '0;
      pdm_o <= '0;
    end
    else
    begin
      for (int i = 0; i < N_PDM; i++)
      begin
        acc_q[i] <= acc_nxt[i][7:0];
        pdm_o[i] <= acc_nxt[i][8];  // carry out
      end
    end
  end

endmodule

/* src/rp_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared definitions for the analog board top level
// sample and bus widths, sample and bus types
// system bus region map and register offsets
// identification word and PDM channel count
//////////////////////////////////////////////////////////////////////

package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // data path widths
  //////////////////////////////////////////////////////////////////////

  localparam int SMP_W = 14;  // DAC and processed sample width
  localparam int ADC_W = 16;  // raw ADC word, two low bits reserved

  typedef logic signed [SMP_W-1:0] smp_t;  // two's complement sample

  //////////////////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] sys_addr_t;
  typedef logic [31:0] sys_data_t;

  localparam int REG_W = 20;  // offset inside a region, bits 22:20 pick the region

  // eight regions, only housekeeping and ams are populated here
  typedef enum logic [2:0] {
    RGN_HK    = 3'd0,
    RGN_SCOPE = 3'd1,
    RGN_ASG   = 3'd2,
    RGN_PID   = 3'd3,
    RGN_AMS   = 3'd4,
    RGN_DAISY = 3'd5,
    RGN_FREE6 = 3'd6,
    RGN_FREE7 = 3'd7
  } region_e;

  // housekeeping map
  localparam logic [REG_W-1:0] HK_ID      = 20'h00;  // read only
  localparam logic [REG_W-1:0] HK_DIGLOOP = 20'h0C;  // bit 0
  localparam logic [REG_W-1:0] HK_LED     = 20'h30;  // 8 bits

  // ams map, one byte per PDM channel
  localparam logic [REG_W-1:0] AMS_PDM0 = 20'h20;
  localparam logic [REG_W-1:0] AMS_PDM1 = 20'h24;
  localparam logic [REG_W-1:0] AMS_PDM2 = 20'h28;
  localparam logic [REG_W-1:0] AMS_PDM3 = 20'h2C;

  localparam sys_data_t RP_ID = 32'h0001_0004;  // board id word

  localparam int N_PDM = 4;  // slow analog outputs

endpackage

/* src/rp_top.sv */
//////////////////////////////////////////////////////////////////////
// board top level, single adc_clk domain
// system bus decoder, housekeeping and ams registers
// PDM outputs and the two channel analog path
//////////////////////////////////////////////////////////////////////

module rp_top (
  input  logic                          adc_clk,
  input  logic                          reset_i,
  // system bus
  input  rp_pkg::sys_addr_t             sys_addr_i,
  input  rp_pkg::sys_data_t             sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output rp_pkg::sys_data_t             sys_rdata_o,
  output logic                          sys_ack_o,
  output logic                          sys_err_o,
  // analog path
  input  logic [1:0][rp_pkg::ADC_W-1:0] adc_dat_i,
  input  rp_pkg::smp_t [1:0]            gen_asg_i,  // from generator engine
  input  rp_pkg::smp_t [1:0]            gen_pid_i,  // from controller engine
  output rp_pkg::smp_t [1:0]            acq_o,
  output logic [1:0][rp_pkg::SMP_W-1:0] dac_o,      // one word per channel
  // board outputs
  output logic [7:0]                    led_o,
  output logic [rp_pkg::N_PDM-1:0]      pdm_o
);
  import rp_pkg::*;

  logic [REG_W-1:0]      rgn_addr;   // offset, common to all blocks
  sys_data_t             rgn_wdata;
  logic                  hk_wen, hk_ren, hk_ack;
  logic                  ams_wen, ams_ren, ams_ack;
  sys_data_t             hk_rdata, ams_rdata;
  logic                  digital_loop;
  logic [N_PDM-1:0][7:0] pdm_cfg;    // duty bytes

  sys_bus_decoder u_dec (
    .adc_clk, .reset_i, .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i,
    .rgn_addr_o (rgn_addr), .rgn_wdata_o (rgn_wdata),
    .hk_wen_o (hk_wen), .hk_ren_o (hk_ren), .ams_wen_o (ams_wen), .ams_ren_o (ams_ren),
    .hk_rdata_i (hk_rdata), .hk_ack_i (hk_ack), .ams_rdata_i (ams_rdata), .ams_ack_i (ams_ack),
    .sys_rdata_o, .sys_ack_o, .sys_err_o
  );

  rp_housekeeping u_hk (
    .adc_clk, .reset_i, .addr_i (rgn_addr), .wdata_i (rgn_wdata),
    .wen_i (hk_wen), .ren_i (hk_ren), .rdata_o (hk_rdata), .ack_o (hk_ack),
    .digital_loop_o (digital_loop), .led_o
  );

  rp_ams_regs u_ams (
    .adc_clk, .reset_i, .addr_i (rgn_addr), .wdata_i (rgn_wdata),
    .wen_i (ams_wen), .ren_i (ams_ren), .rdata_o (ams_rdata), .ack_o (ams_ack),
    .pdm_cfg_o (pdm_cfg)
  );

  rp_pdm u_pdm (.adc_clk, .reset_i, .cfg_i (pdm_cfg), .pdm_o);

  // acquire and generate paths
  rp_analog_io u_aio (
    .adc_clk, .reset_i, .adc_dat_i, .gen_asg_i, .gen_pid_i,
    .digital_loop_i (digital_loop), .acq_o, .dac_o
  );

endmodule

/* src/sys_bus_decoder.sv */
//////////////////////////////////////////////////////////////////////
// system bus decoder
// splits the address space into eight regions
// forwards gated strobes to the owning register block
// multiplexes read data and ack back to the processor side
// answers strobes to unpopulated regions with ack and err
//////////////////////////////////////////////////////////////////////

module sys_bus_decoder (
  input  logic                     adc_clk,
  input  logic                     reset_i,
  input  rp_pkg::sys_addr_t        sys_addr_i,
  input  rp_pkg::sys_data_t        sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [rp_pkg::REG_W-1:0] rgn_addr_o,
  output rp_pkg::sys_data_t        rgn_wdata_o,
  output logic                     hk_wen_o,
  output logic                     hk_ren_o,
  output logic                     ams_wen_o,
  output logic                     ams_ren_o,
  input  rp_pkg::sys_data_t        hk_rdata_i,
  input  logic                     hk_ack_i,
  input  rp_pkg::sys_data_t        ams_rdata_i,
  input  logic                     ams_ack_i,
  output rp_pkg::sys_data_t        sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o
);
  import rp_pkg::*;

  region_e rgn;       // region of current address
  logic    hk_sel;
  logic    ams_sel;
  logic    none_sel;  // nobody lives there
  logic    err_q;     // error reply pulse

  assign rgn         = region_e'(sys_addr_i[REG_W+2:REG_W]);
  assign rgn_addr_o  = sys_addr_i[REG_W-1:0];  // shared by all blocks
  assign rgn_wdata_o = sys_wdata_i;

  always_comb
  begin
    hk_sel   = 1'b0;
    ams_sel  = 1'b0;
    none_sel = 1'b0;
    case (rgn)
      RGN_HK:  hk_sel  = 1'b1;
      RGN_AMS: ams_sel = 1'b1;
      // engines outside this design, plus the spare slots
      RGN_SCOPE, RGN_ASG, RGN_PID, RGN_DAISY, RGN_FREE6, RGN_FREE7: none_sel = 1'b1;
    endcase
  end

  // strobes only reach the selected block
  assign hk_wen_o  = sys_wen_i & hk_sel;
  assign hk_ren_o  = sys_ren_i & hk_sel;
  assign ams_wen_o = sys_wen_i & ams_sel;
  assign ams_ren_o = sys_ren_i & ams_sel;

  //////////////////////////////////////////////////////////////////////
  // reply side
  //////////////////////////////////////////////////////////////////////

  // same one cycle latency as the register blocks
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      err_q <= 1'b0;
    else
      err_q <= none_sel & (sys_wen_i | sys_ren_i);
  end

  // at most one ack per cycle, it picks the data source
  always_comb
  begin
    if (hk_ack_i)
      sys_rdata_o = hk_rdata_i;
    else if (ams_ack_i)
      sys_rdata_o = ams_rdata_i;
    else
      sys_rdata_o = '0;  // error reply reads zero
  end

  assign sys_ack_o = hk_ack_i | ams_ack_i | err_q;
  assign sys_err_o = err_q;  // always alongside ack

endmodule

/* test/rp_top_assertions.sv */
//////////////////////////////////////////////////////////////////////
// concurrent assertions on the top level system bus and reset
// bound into every rp_top instance
//////////////////////////////////////////////////////////////////////

module rp_top_assertions (
  input logic       adc_clk,
  input logic       reset_i,
  input logic       sys_wen_i,
  input logic       sys_ren_i,
  input logic       sys_ack_o,
  input logic       sys_err_o,
  input logic [7:0] led_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;  // failed assertion count

  // every ack answers a strobe of the cycle before
  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (reset_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i))
  else
  begin
    fail_cnt++;
    $error("ack without a strobe one cycle earlier");
  end

  // no strobe goes unanswered, whatever region it hits
  strobe_acked: assert property (@(posedge adc_clk) disable iff (reset_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o)
  else
  begin
    fail_cnt++;
    $error("strobe without ack in the next cycle");
  end

  // registers cleared one edge into reset
  reset_clears: assert property (@(posedge adc_clk)
    (reset_i && $past(reset_i)) |-> (!sys_ack_o && !sys_err_o && led_o == 8'd0))
  else
  begin
    fail_cnt++;
    $error("ack, err or led_o not zero during reset");
  end

endmodule

bind rp_top rp_top_assertions u_asrt (.*);

/* test/rp_top_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the board top level
// clock, reset, system bus write and read tasks
// sample table applied in a loop, normal and digital loop modes
// register, PDM duty and unused region checks
//////////////////////////////////////////////////////////////////////

module rp_top_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rp_pkg::*;

  localparam int N_FIX       = 6;
  localparam int N_ROWS      = 16;  // fixed rows, then random padding
  localparam int ACK_TIMEOUT = 16;  // cycles
  localparam int SMP_MAX     = (1 << (SMP_W-1)) - 1;
  localparam int SMP_MIN     = -(1 << (SMP_W-1));
  localparam logic [7:0]       PDM_DUTY [N_PDM] = '{8'h01, 8'h80, 8'hC3, 8'hFF};
  localparam logic [REG_W-1:0] PDM_OFS [N_PDM]  = '{AMS_PDM0, AMS_PDM1, AMS_PDM2, AMS_PDM3};

  logic                  adc_clk = 1'b0;
  logic                  reset_i;
  sys_addr_t             sys_addr_i;
  sys_data_t             sys_wdata_i;
  logic                  sys_wen_i, sys_ren_i;
  sys_data_t             sys_rdata_o;
  logic                  sys_ack_o, sys_err_o;
  logic [1:0][ADC_W-1:0] adc_dat_i;
  smp_t [1:0]            gen_asg_i, gen_pid_i;
  smp_t [1:0]            acq_o;
  logic [1:0][SMP_W-1:0] dac_o;
  logic [7:0]            led_o;
  logic [N_PDM-1:0]      pdm_o;
  logic [31:0]           lcg_state = 32'h0384_73e0;
  logic                  finished  = 1'b0;  // verdict already printed

  // adc a, adc b (raw words), asg a, asg b, pid a, pid b
  int fixed_rows [N_FIX][6] = '{
    '{'h0000, 'hFFFC,     0,     0,     0,     0},  // both ends of the ADC code
    '{'h8000, 'h7FFC,  1000, -1000,   200,  -200},
    '{'h1234, 'hABCD,  8000, -8000,  1000, -1000},  // overflow both ways
    '{'h0004, 'hFFF8,  8191, -8192,  8191, -8192},  // largest overflow
    '{'h4000, 'hC000,    -5,     7,     5,    -7},
    '{'h0003, 'h7FFF, -8192,  8191,     0,     0}   // extremes, just fits
  };
  int rows [N_ROWS][6];

  rp_top u_rp_top (.*);

  always #50 adc_clk = ~adc_clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // negative slope code, upper 14 bits: full scale low code is +max
  function automatic int adc_expected(input int word);
    return SMP_MAX - word / 4;
  endfunction

  function automatic int saturate(input int sum);
    if (sum > SMP_MAX)
      return SMP_MAX;
    else if (sum < SMP_MIN)
      return SMP_MIN;
    return sum;
  endfunction

  function automatic sys_addr_t region_addr(input region_e rgn, input logic [REG_W-1:0] off);
    return {9'd0, rgn, off};
  endfunction

  task automatic check_value(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      $display("Test failed");
      finished = 1'b1;
      $fatal(1, "value mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////////////////

  task automatic wait_ack(output sys_data_t rdata, output logic err);
    rdata = '0;
    err   = 1'b0;
    for (int cyc = 0; cyc < ACK_TIMEOUT; cyc++)
    begin
      @(posedge adc_clk);
      #5;
      sys_wen_i = 1'b0;  // one cycle strobe
      sys_ren_i = 1'b0;
      if (sys_ack_o)
      begin
        rdata = sys_rdata_o;
        err   = sys_err_o;
        return;
      end
    end
    $display("Error at %0t ns: no ack on the system bus within %0d cycles", $time, ACK_TIMEOUT);
    $display("Test failed");
    finished = 1'b1;
    $fatal(1, "bus timeout");
  endtask

  task automatic bus_write(input sys_addr_t addr, input sys_data_t data);
    sys_data_t rdata;
    logic      err;
    @(posedge adc_clk);
    #5;
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;
    wait_ack(rdata, err);
    check_value("sys_err_o", int'(err), 0);
  endtask

  task automatic bus_read(input sys_addr_t addr, output sys_data_t data, output logic err);
    @(posedge adc_clk);
    #5;
    sys_addr_i = addr;
    sys_ren_i  = 1'b1;
    wait_ack(data, err);
  endtask

  // dac one cycle behind, acq two cycles (normal) or one (loop)
  task automatic run_table(input logic loop_on);
    for (int n = 0; n < N_ROWS + 2; n++)
    begin
      @(posedge adc_clk);
      #5;
      for (int ch = 0; ch < 2; ch++)
      begin
        if (n >= 1 && n <= N_ROWS)
        begin
          check_value($sformatf("dac_o[%0d]", ch), int'(dac_o[ch]),
                      SMP_MAX - saturate(rows[n-1][2+ch] + rows[n-1][4+ch]));
          if (loop_on)
            check_value($sformatf("acq_o[%0d]", ch), int'($signed(acq_o[ch])),
                        saturate(rows[n-1][2+ch] + rows[n-1][4+ch]));
        end
        if (!loop_on && n >= 2)
          check_value($sformatf("acq_o[%0d]", ch), int'($signed(acq_o[ch])),
                      adc_expected(rows[n-2][ch]));
        if (n < N_ROWS)
        begin
          adc_dat_i[ch] = 16'(rows[n][ch]);
          gen_asg_i[ch] = SMP_W'(rows[n][2+ch]);
          gen_pid_i[ch] = SMP_W'(rows[n][4+ch]);
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    sys_data_t   rdata;
    logic        err;
    logic [31:0] rnd;
    int          ones [N_PDM];
    reset_i     = 1'b1;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_i   = '0;
    gen_asg_i   = '0;
    gen_pid_i   = '0;
    for (int i = 0; i < N_ROWS; i++)
    begin
      for (int k = 0; k < 6; k++)
      begin
        rnd        = lcg_next();
        rows[i][k] = (i < N_FIX) ? fixed_rows[i][k]
                   : (k < 2) ? int'(rnd[31:16]) : int'($signed(rnd[29:16]));
      end
    end
    repeat (10) @(posedge adc_clk);
    #5;
    reset_i = 1'b0;

    bus_read(region_addr(RGN_HK, HK_ID), rdata, err);
    check_value("sys_rdata_o", int'(rdata), int'(RP_ID));
    check_value("sys_err_o", int'(err), 0);
    bus_write(region_addr(RGN_HK, HK_LED), 32'h0000_00A5);
    bus_read(region_addr(RGN_HK, HK_LED), rdata, err);
    check_value("sys_rdata_o", int'(rdata), 'hA5);
    check_value("led_o", int'(led_o), 'hA5);

    run_table(1'b0);
    bus_write(region_addr(RGN_HK, HK_DIGLOOP), 32'd1);  // acq now follows the gen sum
    run_table(1'b1);

    for (int ch = 0; ch < N_PDM; ch++)
      bus_write(region_addr(RGN_AMS, PDM_OFS[ch]), {24'd0, PDM_DUTY[ch]});
    ones = '{default: 0};
    repeat (256)  // one full accumulator period
    begin
      @(posedge adc_clk);
      #5;
      for (int ch = 0; ch < N_PDM; ch++)
        ones[ch] = ones[ch] + int'(pdm_o[ch]);
    end
    for (int ch = 0; ch < N_PDM; ch++)
      check_value($sformatf("pdm_o[%0d] ones", ch), ones[ch], int'(PDM_DUTY[ch]));

    bus_read(region_addr(RGN_SCOPE, '0), rdata, err);  // nothing lives in region 1
    check_value("sys_err_o", int'(err), 1);
    check_value("sys_rdata_o", int'(rdata), 0);

    finished = 1'b1;
    if (u_rp_top.u_asrt.fail_cnt == 0)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
    begin
      $display("Error: %0d assertion failures", u_rp_top.u_asrt.fail_cnt);
      $display("Test failed");
      $fatal(1, "assertion failures");
    end
  end

  // simulator stopped early, e.g. on an assertion
  final
  begin
    if (!finished)
      $display("Test failed");
  end

endmodule
